//--- verilog/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and register file
`define XLEN       32
`define REG_ADDR_W 4
`define NUM_REGS   16
`define IMM_W      16

// Queue and reorder buffer sizes
`define IQ_DEPTH   4
`define ROB_DEPTH  8
`define ROB_TAG_W  3

// Multiplier latency in cycles
`define MUL_STAGES 3

`endif

//--- verilog/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

  // Codes 4'h8 to 4'hf are unassigned and decode as OP_NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_ADDI = 4'h6,
    OP_MUL  = 4'h7
  } opcode_e;

  typedef struct packed {
    opcode_e                op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
    logic                   wr;
    logic                   is_mul;
  } dec_inst_t;

  typedef struct packed {
    opcode_e               op;
    logic [`XLEN-1:0]      src_a;
    logic [`XLEN-1:0]      src_b;
    logic [`ROB_TAG_W-1:0] tag;
  } exec_req_t;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic [`XLEN-1:0]      value;
  } complete_t;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       value;
    logic                   wr;
  } retire_t;

endpackage

//--- verilog/inst_queue.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module inst_queue import core_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inst_valid,
  input  logic [`XLEN-1:0] inst_word,
  input  logic             issue_take,
  output logic             inst_ready,
  output logic             head_valid,
  output dec_inst_t        head
);

  localparam int PTR_W   = $clog2(`IQ_DEPTH);
  localparam int RS2_LSB = `IMM_W;
  localparam int RS1_LSB = RS2_LSB + `REG_ADDR_W;
  localparam int RD_LSB  = RS1_LSB + `REG_ADDR_W;
  localparam int OP_LSB  = RD_LSB + `REG_ADDR_W;

  dec_inst_t        fifo_mem [`IQ_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;
  dec_inst_t        decoded;

  assign inst_ready = (count != `IQ_DEPTH);
  assign head_valid = (count != '0);
  assign head       = fifo_mem[rd_ptr];
  assign push       = inst_valid & inst_ready;
  assign pop        = issue_take & head_valid;

  // Decode on the way in
  always_comb begin
    decoded.rd  = inst_word[RD_LSB +: `REG_ADDR_W];
    decoded.rs1 = inst_word[RS1_LSB +: `REG_ADDR_W];
    decoded.rs2 = inst_word[RS2_LSB +: `REG_ADDR_W];
    decoded.imm = {{(`XLEN - `IMM_W){inst_word[`IMM_W-1]}}, inst_word[`IMM_W-1:0]};
    case (inst_word[OP_LSB +: 4])
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MUL:
        decoded.op = opcode_e'(inst_word[OP_LSB +: 4]);
      default:
        decoded.op = OP_NOP;
    endcase
    decoded.wr     = (decoded.op != OP_NOP);
    decoded.is_mul = (decoded.op == OP_MUL);
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= decoded;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- verilog/issue_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module issue_stage import core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  head_valid,
  input  dec_inst_t             head,
  input  logic                  rob_free,
  input  logic [`ROB_TAG_W-1:0] alloc_tag,
  input  logic                  commit_valid,
  input  retire_t               commit,
  output logic                  issue_take,
  output logic                  alloc,
  output retire_t               alloc_rd_info,
  output logic                  alu_valid,
  output logic                  mul_valid,
  output exec_req_t             req
);

  logic [`XLEN-1:0]     regs [`NUM_REGS];
  logic [`NUM_REGS-1:0] pending;
  logic                 hazard;
  logic                 can_issue;
  logic [`XLEN-1:0]     src_a;
  logic [`XLEN-1:0]     src_b;

  // Stall until every source and the destination are settled
  assign hazard     = pending[head.rs1] | pending[head.rs2] | pending[head.rd];
  assign can_issue  = head_valid & rob_free & ~hazard;
  assign issue_take = can_issue;
  assign alloc      = can_issue;

  always_comb begin
    alloc_rd_info.rd    = head.rd;
    alloc_rd_info.value = '0;
    alloc_rd_info.wr    = head.wr;
  end

  // r0 is never written and stays zero
  assign src_a = regs[head.rs1];
  assign src_b = (head.op == OP_ADDI) ? head.imm : regs[head.rs2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (commit_valid && commit.wr && (commit.rd != '0)) begin
      regs[commit.rd] <= commit.value;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      if (commit_valid && commit.wr) begin
        pending[commit.rd] <= 1'b0;
      end
      if (can_issue && head.wr && (head.rd != '0)) begin
        pending[head.rd] <= 1'b1;
      end
    end
  end

  // Dispatch register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_valid <= 1'b0;
      mul_valid <= 1'b0;
    end else begin
      alu_valid <= can_issue & ~head.is_mul;
      mul_valid <= can_issue & head.is_mul;
    end
  end

  always_ff @(posedge clk) begin
    if (can_issue) begin
      req.op    <= head.op;
      req.src_a <= src_a;
      req.src_b <= src_b;
      req.tag   <= alloc_tag;
    end
  end

endmodule

//--- verilog/alu_unit.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module alu_unit import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alu_valid,
  input  exec_req_t req,
  output logic      done_valid,
  output complete_t done
);

  logic [`XLEN-1:0] result;

  always_comb begin
    case (req.op)
      OP_ADD, OP_ADDI: result = req.src_a + req.src_b;
      OP_SUB:          result = req.src_a - req.src_b;
      OP_AND:          result = req.src_a & req.src_b;
      OP_OR:           result = req.src_a | req.src_b;
      OP_XOR:          result = req.src_a ^ req.src_b;
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_valid <= 1'b0;
    end else begin
      done_valid <= alu_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_valid) begin
      done.tag   <= req.tag;
      done.value <= result;
    end
  end

endmodule

//--- verilog/mul_pipe.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module mul_pipe import core_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      mul_valid,
  input  exec_req_t req,
  output logic      done_valid,
  output complete_t done
);

  localparam int HALF = `XLEN / 2;

  logic [`MUL_STAGES-1:0] vld_q;
  logic [`ROB_TAG_W-1:0]  tag_q [`MUL_STAGES];
  logic [`XLEN-1:0]       ll_full;
  logic [`XLEN-1:0]       lh_full;
  logic [`XLEN-1:0]       hl_full;
  logic [`XLEN-1:0]       ll_q;
  logic [HALF-1:0]        lh_q;
  logic [HALF-1:0]        hl_q;
  logic [`XLEN-1:0]       ll2_q;
  logic [HALF-1:0]        cross_q;
  logic [`XLEN-1:0]       prod_q;

  // High x high only affects bits above XLEN
  assign ll_full = req.src_a[HALF-1:0] * req.src_b[HALF-1:0];
  assign lh_full = req.src_a[HALF-1:0] * req.src_b[`XLEN-1:HALF];
  assign hl_full = req.src_a[`XLEN-1:HALF] * req.src_b[HALF-1:0];

  always_ff @(posedge clk) begin
    // Stage 1 partial products
    ll_q    <= ll_full;
    lh_q    <= lh_full[HALF-1:0];
    hl_q    <= hl_full[HALF-1:0];
    // Stage 2 cross terms
    ll2_q   <= ll_q;
    cross_q <= lh_q + hl_q;
    // Stage 3 final sum
    prod_q  <= ll2_q + {cross_q, {HALF{1'b0}}};
  end

  always_ff @(posedge clk) begin
    tag_q[0] <= req.tag;
    for (int i = 1; i < `MUL_STAGES; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[`MUL_STAGES-2:0], mul_valid};
    end
  end

  assign done_valid = vld_q[`MUL_STAGES-1];
  assign done.tag   = tag_q[`MUL_STAGES-1];
  assign done.value = prod_q;

endmodule

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module reorder_buffer import core_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  alloc,
  input  retire_t               alloc_rd_info,
  input  logic                  alu_done_valid,
  input  complete_t             alu_done,
  input  logic                  mul_done_valid,
  input  complete_t             mul_done,
  input  logic                  retire_ready,
  output logic                  rob_free,
  output logic [`ROB_TAG_W-1:0] alloc_tag,
  output logic                  retire_valid,
  output retire_t               retire_data,
  output logic                  commit_valid
);

  logic [`ROB_DEPTH-1:0]  busy;
  logic [`ROB_DEPTH-1:0]  done_bit;
  logic [`ROB_DEPTH-1:0]  wr_flag;
  logic [`REG_ADDR_W-1:0] rd_mem  [`ROB_DEPTH];
  logic [`XLEN-1:0]       val_mem [`ROB_DEPTH];
  logic [`ROB_TAG_W-1:0]  head_ptr;
  logic [`ROB_TAG_W-1:0]  tail_ptr;
  logic [`ROB_TAG_W:0]    count;

  assign rob_free     = (count != `ROB_DEPTH);
  assign alloc_tag    = tail_ptr;
  assign retire_valid = busy[head_ptr] & done_bit[head_ptr];
  assign commit_valid = retire_valid & retire_ready;

  always_comb begin
    retire_data.rd    = rd_mem[head_ptr];
    retire_data.value = val_mem[head_ptr];
    retire_data.wr    = wr_flag[head_ptr];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= '0;
      done_bit <= '0;
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (alloc) begin
        busy[tail_ptr]     <= 1'b1;
        done_bit[tail_ptr] <= 1'b0;
        tail_ptr           <= tail_ptr + 1'b1;
      end
      // Both completion ports carry distinct tags
      if (alu_done_valid) begin
        done_bit[alu_done.tag] <= 1'b1;
      end
      if (mul_done_valid) begin
        done_bit[mul_done.tag] <= 1'b1;
      end
      if (commit_valid) begin
        busy[head_ptr] <= 1'b0;
        head_ptr       <= head_ptr + 1'b1;
      end
      case ({alloc, commit_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      rd_mem[tail_ptr]  <= alloc_rd_info.rd;
      wr_flag[tail_ptr] <= alloc_rd_info.wr;
    end
    if (alu_done_valid) begin
      val_mem[alu_done.tag] <= alu_done.value;
    end
    if (mul_done_valid) begin
      val_mem[mul_done.tag] <= mul_done.value;
    end
  end

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module cpu_core import core_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inst_valid,
  input  logic [`XLEN-1:0] inst_word,
  input  logic             retire_ready,
  output logic             inst_ready,
  output logic             retire_valid,
  output retire_t          retire_data
);

  logic                  head_valid;
  dec_inst_t             iq_head;
  logic                  issue_take;
  logic                  rob_free;
  logic [`ROB_TAG_W-1:0] alloc_tag;
  logic                  alloc;
  retire_t               alloc_rd_info;
  logic                  commit_valid;
  logic                  alu_valid;
  logic                  mul_valid;
  exec_req_t             exec_req;
  logic                  alu_done_valid;
  complete_t             alu_done;
  logic                  mul_done_valid;
  complete_t             mul_done;

  inst_queue iq (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst_word  (inst_word),
    .issue_take (issue_take),
    .inst_ready (inst_ready),
    .head_valid (head_valid),
    .head       (iq_head)
  );

  // Commit writes back through the same retire data seen outside
  issue_stage iss (
    .clk           (clk),
    .rst_n         (rst_n),
    .head_valid    (head_valid),
    .head          (iq_head),
    .rob_free      (rob_free),
    .alloc_tag     (alloc_tag),
    .commit_valid  (commit_valid),
    .commit        (retire_data),
    .issue_take    (issue_take),
    .alloc         (alloc),
    .alloc_rd_info (alloc_rd_info),
    .alu_valid     (alu_valid),
    .mul_valid     (mul_valid),
    .req           (exec_req)
  );

  alu_unit alu (
    .clk        (clk),
    .rst_n      (rst_n),
    .alu_valid  (alu_valid),
    .req        (exec_req),
    .done_valid (alu_done_valid),
    .done       (alu_done)
  );

  mul_pipe mul (
    .clk        (clk),
    .rst_n      (rst_n),
    .mul_valid  (mul_valid),
    .req        (exec_req),
    .done_valid (mul_done_valid),
    .done       (mul_done)
  );

  reorder_buffer rob (
    .clk            (clk),
    .rst_n          (rst_n),
    .alloc          (alloc),
    .alloc_rd_info  (alloc_rd_info),
    .alu_done_valid (alu_done_valid),
    .alu_done       (alu_done),
    .mul_done_valid (mul_done_valid),
    .mul_done       (mul_done),
    .retire_ready   (retire_ready),
    .rob_free       (rob_free),
    .alloc_tag      (alloc_tag),
    .retire_valid   (retire_valid),
    .retire_data    (retire_data),
    .commit_valid   (commit_valid)
  );

endmodule

//--- tests/cpu_core_checker.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module cpu_core_checker import core_pkg::*; (
  input logic             clk,
  input logic             rst_n,
  input logic             inst_valid,
  input logic [`XLEN-1:0] inst_word,
  input logic             retire_ready,
  input logic             retire_valid,
  input retire_t          retire_data
);

  // Low in reset and in the first cycle out of it
  retire_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !retire_valid)
    else $error("retire_valid high right after reset");

  retire_held_when_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_data))
    else $error("retire_valid or retire_data changed while retire_ready was low");

  inst_word_known: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid |-> !$isunknown(inst_word))
    else $error("inst_word has unknown bits while inst_valid is high");

endmodule

bind cpu_core cpu_core_checker cpu_core_checker_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .inst_valid   (inst_valid),
  .inst_word    (inst_word),
  .retire_ready (retire_ready),
  .retire_valid (retire_valid),
  .retire_data  (retire_data)
);

//--- tests/cpu_core_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module cpu_core_tb import core_pkg::*; ();

  // Vector columns are word, rd, value and write flag
  localparam int VEC_COLS   = 4;
  localparam int NUM_VEC    = 28;
  localparam int MAX_CYCLES = 20 * NUM_VEC + 100;

  logic             clk;
  logic             rst_n;
  logic             inst_valid;
  logic [`XLEN-1:0] inst_word;
  logic             retire_ready;
  logic             inst_ready;
  logic             retire_valid;
  retire_t          retire_data;

  logic [`XLEN-1:0] vec_mem [NUM_VEC*VEC_COLS];
  int               send_idx;
  int               ret_idx;
  int               cycles;
  integer           seed;
  logic             saw_full;

  cpu_core cpu_core_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst_word    (inst_word),
    .retire_ready (retire_ready),
    .inst_ready   (inst_ready),
    .retire_valid (retire_valid),
    .retire_data  (retire_data)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [`XLEN-1:0] actual,
                             input logic [`XLEN-1:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "retirement %0d does not match its vector", ret_idx);
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    inst_valid   = 1'b0;
    inst_word    = '0;
    retire_ready = 1'b0;
    send_idx     = 0;
    ret_idx      = 0;
    cycles       = 0;
    saw_full     = 1'b0;
    seed         = 32'h2821;
    $readmemh("tests/cpu_core_vectors.txt", vec_mem);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

  // Next word goes out once the current one is taken
  always @(posedge clk) begin
    int          next_idx;
    logic [31:0] rnd;
    next_idx = send_idx;
    if (inst_valid && inst_ready) begin
      next_idx = send_idx + 1;
    end
    rnd = $random(seed);
    send_idx <= next_idx;
    if (rst_n && next_idx < NUM_VEC) begin
      inst_valid <= 1'b1;
      inst_word  <= vec_mem[next_idx*VEC_COLS];
    end else begin
      inst_valid <= 1'b0;
      inst_word  <= '0;
    end
    retire_ready <= rst_n & rnd[0];
  end

  // Retire checks, end of run and timeout
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (rst_n && !inst_ready) begin
      saw_full <= 1'b1;
    end
    if (retire_valid && retire_ready) begin
      ret_idx <= ret_idx + 1;
      if (ret_idx >= NUM_VEC) begin
        $display("A retirement arrived after all %0d instructions had retired", NUM_VEC);
        $display("SIMULATION FAILED");
        $fatal(1, "extra retirement");
      end else begin
        check_value("retire_data.rd",
                    {{(`XLEN-`REG_ADDR_W){1'b0}}, retire_data.rd},
                    vec_mem[ret_idx*VEC_COLS+1]);
        check_value("retire_data.value", retire_data.value,
                    vec_mem[ret_idx*VEC_COLS+2]);
        check_value("retire_data.wr", {{(`XLEN-1){1'b0}}, retire_data.wr},
                    vec_mem[ret_idx*VEC_COLS+3]);
      end
    end else if (ret_idx == NUM_VEC) begin
      if (saw_full) begin
        $display("SIMULATION PASSED");
        $finish;
      end else begin
        $display("inst_ready never dropped, so the input back-pressure was not seen");
        $display("SIMULATION FAILED");
        $fatal(1, "no back-pressure at the input");
      end
    end else if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, retirements are missing (%0d of %0d seen)",
               cycles, ret_idx, NUM_VEC);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule

//--- cpu_core.f
+incdir+verilog
verilog/core_pkg.sv
verilog/inst_queue.sv
verilog/issue_stage.sv
verilog/alu_unit.sv
verilog/mul_pipe.sv
verilog/reorder_buffer.sv
verilog/cpu_core.sv
tests/cpu_core_checker.sv
tests/cpu_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test: passed" || (echo "test: failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/cpu_core_vectors.txt
// Columns: instruction word, expected rd, expected retire value, expected write flag
// Word fields: opcode[31:28] rd[27:24] rs1[23:20] rs2[19:16] imm[15:0]
61000005 1 00000005 1
6200FFFD 2 FFFFFFFD 1
13120000 3 00000002 1
24120000 4 00000008 1
25340000 5 FFFFFFFA 1
66000F0F 6 00000F0F 1
67007FF0 7 00007FF0 1
38670000 8 00000F00 1
49670000 9 00007FFF 1
5A670000 A 000070FF 1
60100064 0 00000069 1
1B010000 B 00000005 1
7C270000 C FFFE8030 1
6D000007 D 00000007 1
7EDD0000 E 00000031 1
7F9A0000 F 387F0F01 1
93120000 3 00000000 0
13300000 3 00000002 1
61100001 1 00000006 1
11110000 1 0000000C 1
711E0000 1 0000024C 1
221D0000 2 00000245 1
542C0000 4 FFFE8275 1
F4000000 4 00000000 0
45400000 5 FFFE8275 1
76530000 6 FFFD04EA 1
176B0000 7 FFFD04EF 1
28010000 8 FFFFFDB4 1
